// File: arcade_pkg.sv
// arcade front end shared definitions
// memory write port word, download address views, player control
// and analog words, key scan codes, joystick bit positions and
// the download region, reset and analog step constants
`default_nettype none

package arcade_pkg;

	// ========================================
	// download regions and timing constants
	// ========================================
	localparam logic [24:0] CSD_BASE    = 25'h0010000;
	localparam logic [24:0] SPRITE_BASE = 25'h0018000;
	localparam logic [24:0] SPRITE_END  = 25'h0038000;

	localparam logic [7:0] RESET_HOLD   = 8'd255;

	localparam logic [7:0] STEER_CENTER = 8'h80;
	localparam logic [7:0] STEER_STEP   = 8'd4;
	localparam logic [7:0] GAS_STEP     = 8'd8;

	// ========================================
	// keyboard scan codes
	// ========================================
	localparam logic [7:0] KEY_UP      = 8'h75;
	localparam logic [7:0] KEY_DOWN    = 8'h72;
	localparam logic [7:0] KEY_LEFT    = 8'h6B;
	localparam logic [7:0] KEY_RIGHT   = 8'h74;
	localparam logic [7:0] KEY_GUN     = 8'h14;
	localparam logic [7:0] KEY_MISSILE = 8'h11;
	localparam logic [7:0] KEY_SHIFT   = 8'h29;
	localparam logic [7:0] KEY_VAN     = 8'h0D;
	localparam logic [7:0] KEY_OIL     = 8'h12;
	localparam logic [7:0] KEY_SMOKE   = 8'h1A;
	localparam logic [7:0] KEY_COIN    = 8'h2E;
	localparam logic [7:0] KEY_START   = 8'h16;

	// joystick word bit positions
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE_A = 4;
	localparam int JOY_FIRE_B = 5;
	localparam int JOY_FIRE_C = 6;
	localparam int JOY_FIRE_D = 7;
	localparam int JOY_FIRE_E = 8;
	localparam int JOY_FIRE_F = 9;
	localparam int JOY_COIN   = 10;
	localparam int JOY_START  = 11;

	// ========================================
	// types
	// ========================================
	// field split used by the 16-bit rom swizzle
	typedef struct packed {
		logic [8:0]  bank;
		logic        bit15;
		logic        bit14;
		logic [13:0] low;
	} addr_fields_t;

	typedef union packed {
		logic [24:0]  flat;
		addr_fields_t f;
	} ioctl_addr_u;

	// one sdram write port, req toggles once per write
	typedef struct packed {
		logic        req;
		logic [22:0] addr;
		logic [1:0]  ds;
		logic [7:0]  data;
	} mem_wr_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic gun;
		logic missile;
		logic van;
		logic oil;
		logic smoke;
		logic coin;
		logic start;
		logic shift_state;
	} player_ctrl_t;

	typedef struct packed {
		logic [7:0] steering;
		logic [7:0] gas;
	} analog_t;

endpackage

`default_nettype wire

// File: rom_loader.sv
// rom download path
// watches the host download stream and turns each index 0 byte into
// a toggle-style write on two sdram ports. port1 takes the 8/16-bit
// program roms, port2 the sprite roms merged into 32-bit words
`timescale 1ns/1ps
`default_nettype none

module rom_loader (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic                ioctl_download,
	input  logic                ioctl_wr,
	input  logic [7:0]          ioctl_index,
	input  logic [24:0]         ioctl_addr,
	input  logic [7:0]          ioctl_dout,
	output arcade_pkg::mem_wr_t port1,
	output arcade_pkg::mem_wr_t port2,
	output logic                rom_loaded_evt
);

	logic                    wr_d;
	logic                    dl_d;
	logic                    wr_evt;
	logic                    wr_pend;
	arcade_pkg::ioctl_addr_u addr_q;
	logic [7:0]              dout_q;
	logic [24:0]             rom_addr;
	logic [24:0]             sp_off;

	logic                    p1_req;
	logic                    p2_req;
	logic [22:0]             p1_addr;
	logic [22:0]             p2_addr;
	logic [1:0]              p1_ds;
	logic [1:0]              p2_ds;
	logic [7:0]              data_q;

	// rising write strobe of a rom byte
	assign wr_evt = ioctl_download & ioctl_wr & ~wr_d & (ioctl_index == 8'd0);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_d           <= 1'b0;
			dl_d           <= 1'b0;
			wr_pend        <= 1'b0;
			rom_loaded_evt <= 1'b0;
			p1_req         <= 1'b0;
			p2_req         <= 1'b0;
		end else begin
			wr_d           <= ioctl_wr;
			dl_d           <= ioctl_download;
			wr_pend        <= wr_evt;
			rom_loaded_evt <= dl_d & ~ioctl_download;
			if (wr_pend) begin
				p1_req <= ~p1_req;
				p2_req <= ~p2_req;
			end
		end
	end

	// byte and address captured at the write edge
	always_ff @(posedge clk_sys) begin
		if (wr_evt) begin
			addr_q.flat <= ioctl_addr;
			dout_q      <= ioctl_dout;
		end
	end

	// ========================================
	// address remap
	// ========================================
	always_comb begin
		if (addr_q.flat < arcade_pkg::CSD_BASE) begin
			rom_addr = addr_q.flat;
		end else begin
			// 16-bit csd rom, bit14 moves to the byte lane
			rom_addr = {addr_q.f.bank, addr_q.f.bit15, addr_q.f.low, addr_q.f.bit14};
		end
		sp_off = addr_q.flat - arcade_pkg::SPRITE_BASE;
	end

	always_ff @(posedge clk_sys) begin
		if (wr_pend) begin
			p1_addr <= rom_addr[23:1];
			p1_ds   <= {rom_addr[0], ~rom_addr[0]};
			// four sprite roms share one 32-bit word
			p2_addr <= {sp_off[23:17], sp_off[14:0], sp_off[16]};
			p2_ds   <= {sp_off[15], ~sp_off[15]};
			data_q  <= dout_q;
		end
	end

	assign port1 = '{req: p1_req, addr: p1_addr, ds: p1_ds, data: data_q};
	assign port2 = '{req: p2_req, addr: p2_addr, ds: p2_ds, data: data_q};

	// requests only move as a result of a write seen during download
	a_req_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$changed({p1_req, p2_req}) |-> $past(ioctl_download, 2));

	a_loaded_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rom_loaded_evt |=> !rom_loaded_evt);

endmodule

`default_nettype wire

// File: reset_gen.sv
// core reset generation
// keeps the game core in reset until the roms are loaded and while
// the status or button reset is held, then issues a second one-cycle
// reset pulse once the hold counter has run down
`timescale 1ns/1ps
`default_nettype none

module reset_gen (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic rom_loaded_evt,
	input  logic status_reset,
	input  logic button_reset,
	output logic core_reset
);

	logic       rom_loaded;
	logic       loaded_nxt;
	logic       hold_src;
	logic [7:0] hold_cnt;

	assign loaded_nxt = rom_loaded | rom_loaded_evt;

	// any source that keeps the core in reset
	assign hold_src = status_reset | button_reset | ~loaded_nxt;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rom_loaded <= 1'b0;
			hold_cnt   <= arcade_pkg::RESET_HOLD;
			core_reset <= 1'b1;
		end else begin
			rom_loaded <= loaded_nxt;
			if (hold_src) begin
				hold_cnt <= arcade_pkg::RESET_HOLD;
			end else if (hold_cnt != 8'd0) begin
				hold_cnt <= hold_cnt - 8'd1;
			end
			// second pulse while the counter passes 1
			core_reset <= hold_src | (hold_cnt == 8'd1);
		end
	end

	a_reset_until_loaded: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!rom_loaded |-> core_reset);

endmodule

`default_nettype wire

// File: control_mapper.sv
// player control mapping
// latches keyboard state per mapped scan code, merges the joystick,
// turns the directions for a rotated screen and keeps the gearbox
// shift state, which a coin press clears
`timescale 1ns/1ps
`default_nettype none

module control_mapper (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     key_strobe,
	input  logic                     key_pressed,
	input  logic [7:0]               key_code,
	input  logic [15:0]              joystick,
	input  logic                     rotate,
	output arcade_pkg::player_ctrl_t ctrl
);

	logic key_up, key_down, key_left, key_right;
	logic key_gun, key_missile, key_shift, key_van;
	logic key_oil, key_smoke, key_coin, key_start;

	logic up_in, down_in, left_in, right_in;
	logic shift_in, coin_in;
	logic shift_d, coin_d;
	arcade_pkg::player_ctrl_t ctrl_nxt;

	// ========================================
	// key latches
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			{key_up, key_down, key_left, key_right}       <= 4'b0;
			{key_gun, key_missile, key_shift, key_van}    <= 4'b0;
			{key_oil, key_smoke, key_coin, key_start}     <= 4'b0;
		end else if (key_strobe) begin
			case (key_code)
				arcade_pkg::KEY_UP:      key_up      <= key_pressed;
				arcade_pkg::KEY_DOWN:    key_down    <= key_pressed;
				arcade_pkg::KEY_LEFT:    key_left    <= key_pressed;
				arcade_pkg::KEY_RIGHT:   key_right   <= key_pressed;
				arcade_pkg::KEY_GUN:     key_gun     <= key_pressed;
				arcade_pkg::KEY_MISSILE: key_missile <= key_pressed;
				arcade_pkg::KEY_SHIFT:   key_shift   <= key_pressed;
				arcade_pkg::KEY_VAN:     key_van     <= key_pressed;
				arcade_pkg::KEY_OIL:     key_oil     <= key_pressed;
				arcade_pkg::KEY_SMOKE:   key_smoke   <= key_pressed;
				arcade_pkg::KEY_COIN:    key_coin    <= key_pressed;
				arcade_pkg::KEY_START:   key_start   <= key_pressed;
				default: ;
			endcase
		end
	end

	// keyboard or joystick
	assign up_in    = key_up    | joystick[arcade_pkg::JOY_UP];
	assign down_in  = key_down  | joystick[arcade_pkg::JOY_DOWN];
	assign left_in  = key_left  | joystick[arcade_pkg::JOY_LEFT];
	assign right_in = key_right | joystick[arcade_pkg::JOY_RIGHT];
	assign shift_in = key_shift | joystick[arcade_pkg::JOY_FIRE_C];
	assign coin_in  = key_coin  | joystick[arcade_pkg::JOY_COIN];

	always_comb begin
		if (rotate) begin
			// quarter turn clockwise
			ctrl_nxt.up    = left_in;
			ctrl_nxt.right = up_in;
			ctrl_nxt.down  = right_in;
			ctrl_nxt.left  = down_in;
		end else begin
			ctrl_nxt.up    = up_in;
			ctrl_nxt.right = right_in;
			ctrl_nxt.down  = down_in;
			ctrl_nxt.left  = left_in;
		end
		ctrl_nxt.gun     = key_gun     | joystick[arcade_pkg::JOY_FIRE_A];
		ctrl_nxt.missile = key_missile | joystick[arcade_pkg::JOY_FIRE_B];
		ctrl_nxt.van     = key_van     | joystick[arcade_pkg::JOY_FIRE_D];
		ctrl_nxt.oil     = key_oil     | joystick[arcade_pkg::JOY_FIRE_E];
		ctrl_nxt.smoke   = key_smoke   | joystick[arcade_pkg::JOY_FIRE_F];
		ctrl_nxt.coin    = coin_in;
		ctrl_nxt.start   = key_start   | joystick[arcade_pkg::JOY_START];

		// gearbox, coin wins over shift
		ctrl_nxt.shift_state = ctrl.shift_state;
		if (coin_in && !coin_d) begin
			ctrl_nxt.shift_state = 1'b0;
		end else if (shift_in && !shift_d) begin
			ctrl_nxt.shift_state = ~ctrl.shift_state;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ctrl    <= '0;
			shift_d <= 1'b0;
			coin_d  <= 1'b0;
		end else begin
			ctrl    <= ctrl_nxt;
			shift_d <= shift_in;
			coin_d  <= coin_in;
		end
	end

endmodule

`default_nettype wire

// File: analog_control.sv
// analog steering and gas emulation
// ramps the steering wheel and gas pedal values from the digital
// direction controls, one step per vertical sync. steering returns
// to center when released, gas holds its value
`timescale 1ns/1ps
`default_nettype none

module analog_control (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     vsync,
	input  arcade_pkg::player_ctrl_t ctrl,
	output arcade_pkg::analog_t      analog
);

	logic                vs_d;
	logic                step_q;
	arcade_pkg::analog_t analog_nxt;

	function automatic logic [7:0] sat_add(input logic [7:0] v, input logic [7:0] s);
		logic [8:0] sum;
		sum = {1'b0, v} + {1'b0, s};
		return sum[8] ? 8'hFF : sum[7:0];
	endfunction

	function automatic logic [7:0] sat_sub(input logic [7:0] v, input logic [7:0] s);
		return (v < s) ? 8'h00 : v - s;
	endfunction

	// ========================================
	// next values for one frame step
	// ========================================
	always_comb begin
		analog_nxt = analog;
		if (ctrl.right && !ctrl.left) begin
			analog_nxt.steering = sat_add(analog.steering, arcade_pkg::STEER_STEP);
		end else if (ctrl.left && !ctrl.right) begin
			analog_nxt.steering = sat_sub(analog.steering, arcade_pkg::STEER_STEP);
		end else if (analog.steering > arcade_pkg::STEER_CENTER) begin
			// back to center without passing it
			if (analog.steering - arcade_pkg::STEER_CENTER < arcade_pkg::STEER_STEP)
				analog_nxt.steering = arcade_pkg::STEER_CENTER;
			else
				analog_nxt.steering = analog.steering - arcade_pkg::STEER_STEP;
		end else if (analog.steering < arcade_pkg::STEER_CENTER) begin
			if (arcade_pkg::STEER_CENTER - analog.steering < arcade_pkg::STEER_STEP)
				analog_nxt.steering = arcade_pkg::STEER_CENTER;
			else
				analog_nxt.steering = analog.steering + arcade_pkg::STEER_STEP;
		end

		if (ctrl.up && !ctrl.down) begin
			analog_nxt.gas = sat_add(analog.gas, arcade_pkg::GAS_STEP);
		end else if (ctrl.down && !ctrl.up) begin
			analog_nxt.gas = sat_sub(analog.gas, arcade_pkg::GAS_STEP);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vs_d   <= 1'b0;
			step_q <= 1'b0;
			analog <= '{steering: arcade_pkg::STEER_CENTER, gas: 8'd0};
		end else begin
			vs_d   <= vsync;
			step_q <= vsync & ~vs_d;
			if (step_q)
				analog <= analog_nxt;
		end
	end

	a_step_on_vsync: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$changed(analog) |-> $past(vsync & ~vs_d, 2));

endmodule

`default_nettype wire

// File: spyhunt_front.sv
// car-chase arcade board front end
// rom download to the two sdram write ports, core reset generation,
// and player controls with analog steering and gas for player one
`timescale 1ns/1ps
`default_nettype none

module spyhunt_front (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     ioctl_download,
	input  logic                     ioctl_wr,
	input  logic [7:0]               ioctl_index,
	input  logic [24:0]              ioctl_addr,
	input  logic [7:0]               ioctl_dout,
	input  logic                     key_strobe,
	input  logic                     key_pressed,
	input  logic [7:0]               key_code,
	input  logic [15:0]              joystick_0,
	input  logic                     status_reset,
	input  logic                     button_reset,
	input  logic                     rotate,
	input  logic                     vsync,
	output arcade_pkg::mem_wr_t      port1,
	output arcade_pkg::mem_wr_t      port2,
	output logic                     core_reset,
	output arcade_pkg::player_ctrl_t ctrl,
	output arcade_pkg::analog_t      analog
);

	logic rom_loaded_evt;

	rom_loader rom_loader_inst (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.port1          (port1),
		.port2          (port2),
		.rom_loaded_evt (rom_loaded_evt)
	);

	reset_gen reset_gen_inst (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.rom_loaded_evt (rom_loaded_evt),
		.status_reset   (status_reset),
		.button_reset   (button_reset),
		.core_reset     (core_reset)
	);

	control_mapper control_mapper_inst (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joystick    (joystick_0),
		.rotate      (rotate),
		.ctrl        (ctrl)
	);

	analog_control analog_control_inst (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.vsync   (vsync),
		.ctrl    (ctrl),
		.analog  (analog)
	);

endmodule

`default_nettype wire

// File: tb_spyhunt_front.sv
// testbench for the car-chase arcade front end
// drives rom downloads, core reset sources, keys, joystick and vsync
// and compares the outputs with reference models of the address remap,
// screen rotation and analog step rules
`timescale 1ns/1ps
`default_nettype none

module tb_spyhunt_front;

	localparam int N_WR        = 24;
	localparam int ANA_PULSES  = 244;
	localparam int DL_CYCLES   = 3 * N_WR * 4 + 64;
	localparam int RST_CYCLES  = 2 * 255 + 64;
	localparam int MAP_CYCLES  = 256;
	localparam int ANA_CYCLES  = ANA_PULSES * 3 + 64;
	localparam int WDOG_CYCLES = DL_CYCLES + RST_CYCLES + MAP_CYCLES + ANA_CYCLES + 200;

	logic        clk_sys, rst_n;
	logic        ioctl_download, ioctl_wr;
	logic [7:0]  ioctl_index, ioctl_dout;
	logic [24:0] ioctl_addr;
	logic        key_strobe, key_pressed;
	logic [7:0]  key_code;
	logic [15:0] joystick_0;
	logic        status_reset, button_reset, rotate, vsync;

	arcade_pkg::mem_wr_t      port1, port2;
	logic                     core_reset;
	arcade_pkg::player_ctrl_t ctrl;
	arcade_pkg::analog_t      analog;

	int          errors;
	int          checks;
	logic [31:0] lcg_state;
	logic [7:0]  exp_steer;
	logic [7:0]  exp_gas;
	logic [7:0]  key_tab [0:10];
	int          joy_tab [0:10];

	spyhunt_front spyhunt_front_inst (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr),
		.ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.key_strobe(key_strobe), .key_pressed(key_pressed), .key_code(key_code),
		.joystick_0(joystick_0), .status_reset(status_reset),
		.button_reset(button_reset), .rotate(rotate), .vsync(vsync),
		.port1(port1), .port2(port2), .core_reset(core_reset),
		.ctrl(ctrl), .analog(analog)
	);

	initial clk_sys = 1'b0;
	always #20 clk_sys = ~clk_sys;

	// ========================================
	// reference models
	// ========================================
	function logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 8;
	endfunction

	// returns {word address, ds}
	function automatic logic [24:0] ref_port1(input logic [24:0] a);
		logic [24:0] r;
		if (a < arcade_pkg::CSD_BASE)
			r = a;
		else
			r = {a[24:16], a[15], a[13:0], a[14]};
		return {r[23:1], r[0], ~r[0]};
	endfunction

	function automatic logic [24:0] ref_port2(input logic [24:0] a);
		logic [24:0] off;
		off = a - arcade_pkg::SPRITE_BASE;
		return {off[23:17], off[14:0], off[16], off[15], ~off[15]};
	endfunction

	// quarter turn clockwise of the directions {up, down, left, right}
	function automatic logic [3:0] ref_rotate(input logic [3:0] d);
		return {d[1], d[0], d[2], d[3]};
	endfunction

	function automatic logic [7:0] ref_steer(input logic [7:0] s, input logic l, input logic r);
		int v;
		int c;
		int st;
		v  = int'(s);
		c  = int'(arcade_pkg::STEER_CENTER);
		st = int'(arcade_pkg::STEER_STEP);
		if (r && !l)
			v = (v + st > 255) ? 255 : v + st;
		else if (l && !r)
			v = (v - st < 0) ? 0 : v - st;
		else if (v > c)
			v = (v - c < st) ? c : v - st;
		else if (v < c)
			v = (c - v < st) ? c : v + st;
		return v[7:0];
	endfunction

	function automatic logic [7:0] ref_gas(input logic [7:0] g, input logic u, input logic d);
		int v;
		int st;
		v  = int'(g);
		st = int'(arcade_pkg::GAS_STEP);
		if (u && !d)
			v = (v + st > 255) ? 255 : v + st;
		else if (d && !u)
			v = (v - st < 0) ? 0 : v - st;
		return v[7:0];
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		if (exp !== got) begin
			$display("ERROR %s exp=%h got=%h", name, exp, got);
			errors++;
		end
	endtask

	// ========================================
	// stimulus tasks driving at +2 ns and sampling at +1 ns
	// ========================================
	task automatic rom_write(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		logic        req1_old;
		logic        req2_old;
		logic [24:0] exp1;
		logic [24:0] exp2;
		int          wait_n;
		req1_old = port1.req;
		req2_old = port2.req;
		#1;
		ioctl_index = index;
		ioctl_addr  = addr;
		ioctl_dout  = data;
		ioctl_wr    = 1'b1;
		@(posedge clk_sys);
		#2 ioctl_wr = 1'b0;
		if (index == 8'd0) begin
			wait_n = 0;
			do begin
				@(posedge clk_sys);
				#1 wait_n++;
			end while (port1.req == req1_old && wait_n < 4);
			if (port1.req == req1_old) begin
				$display("port1 request did not toggle after a write to address %h", addr);
				errors++;
			end else begin
				exp1 = ref_port1(addr);
				exp2 = ref_port2(addr);
				check_val("port2.req", 32'(!req2_old), 32'(port2.req));
				check_val("port1.addr", 32'(exp1[24:2]), 32'(port1.addr));
				check_val("port1.ds", 32'(exp1[1:0]), 32'(port1.ds));
				check_val("port1.data", 32'(data), 32'(port1.data));
				check_val("port2.addr", 32'(exp2[24:2]), 32'(port2.addr));
				check_val("port2.ds", 32'(exp2[1:0]), 32'(port2.ds));
				check_val("port2.data", 32'(data), 32'(port2.data));
			end
		end else begin
			repeat (3) begin
				@(posedge clk_sys);
				#1;
			end
			check_val("port1.req", 32'(req1_old), 32'(port1.req));
			check_val("port2.req", 32'(req2_old), 32'(port2.req));
		end
	endtask

	task automatic key_event(input logic [7:0] code, input logic pressed);
		#1;
		key_code    = code;
		key_pressed = pressed;
		key_strobe  = 1'b1;
		@(posedge clk_sys);
		#2 key_strobe = 1'b0;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic apply_inputs(input logic [15:0] joy, input logic rot);
		#1;
		joystick_0 = joy;
		rotate     = rot;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic vsync_step();
		#1 vsync = 1'b1;
		@(posedge clk_sys);
		#2 vsync = 1'b0;
		@(posedge clk_sys);
		#1;
	endtask

	// waits for core_reset to reach a level, returns the cycles taken
	task automatic wait_reset_level(input logic level, input int limit, output int n);
		n = 0;
		do begin
			@(posedge clk_sys);
			#1 n++;
		end while (core_reset != level && n < limit);
	endtask

	task automatic analog_phase(input logic [15:0] joy, input int pulses);
		apply_inputs(joy, 1'b0);
		repeat (pulses) begin
			vsync_step();
			exp_steer = ref_steer(exp_steer, joy[arcade_pkg::JOY_LEFT], joy[arcade_pkg::JOY_RIGHT]);
			exp_gas   = ref_gas(exp_gas, joy[arcade_pkg::JOY_UP], joy[arcade_pkg::JOY_DOWN]);
			check_val("analog.steering", 32'(exp_steer), 32'(analog.steering));
			check_val("analog.gas", 32'(exp_gas), 32'(analog.gas));
		end
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial begin
		logic [31:0] a;
		logic [11:0] exp_ctrl;
		logic [3:0]  dirs;
		logic        exp_shift;
		int          n;
		rst_n = 1'b0;
		{ioctl_download, ioctl_wr, ioctl_index, ioctl_addr, ioctl_dout} = '0;
		{key_strobe, key_pressed, key_code, joystick_0} = '0;
		{status_reset, button_reset, rotate, vsync} = '0;
		errors    = 0;
		checks    = 0;
		lcg_state = 32'd88;
		exp_steer = arcade_pkg::STEER_CENTER;
		exp_gas   = 8'd0;
		exp_shift = 1'b0;
		key_tab = '{arcade_pkg::KEY_UP, arcade_pkg::KEY_DOWN, arcade_pkg::KEY_LEFT,
			arcade_pkg::KEY_RIGHT, arcade_pkg::KEY_GUN, arcade_pkg::KEY_MISSILE,
			arcade_pkg::KEY_VAN, arcade_pkg::KEY_OIL, arcade_pkg::KEY_SMOKE,
			arcade_pkg::KEY_COIN, arcade_pkg::KEY_START};
		joy_tab = '{arcade_pkg::JOY_UP, arcade_pkg::JOY_DOWN, arcade_pkg::JOY_LEFT,
			arcade_pkg::JOY_RIGHT, arcade_pkg::JOY_FIRE_A, arcade_pkg::JOY_FIRE_B,
			arcade_pkg::JOY_FIRE_D, arcade_pkg::JOY_FIRE_E, arcade_pkg::JOY_FIRE_F,
			arcade_pkg::JOY_COIN, arcade_pkg::JOY_START};
		repeat (5) @(posedge clk_sys);
		#2 rst_n = 1'b1;
		@(posedge clk_sys);
		#1;

		// download into the three regions, then writes of other indexes
		#1 ioctl_download = 1'b1;
		@(posedge clk_sys);
		#1 check_val("core_reset", 32'd1, 32'(core_reset));
		for (int r = 0; r < 3; r++) begin
			for (int i = 0; i < N_WR; i++) begin
				case (r)
					0: a = lcg_next() % 32'(arcade_pkg::CSD_BASE);
					1: a = 32'(arcade_pkg::CSD_BASE)
						+ lcg_next() % 32'(arcade_pkg::SPRITE_BASE - arcade_pkg::CSD_BASE);
					default: a = 32'(arcade_pkg::SPRITE_BASE)
						+ lcg_next() % 32'(arcade_pkg::SPRITE_END - arcade_pkg::SPRITE_BASE);
				endcase
				rom_write(8'd0, a[24:0], 8'(lcg_next() >> 12));
			end
		end
		for (int i = 1; i < 5; i++)
			rom_write(8'(i), 25'(lcg_next()), 8'(lcg_next()));
		check_val("core_reset", 32'd1, 32'(core_reset));

		// end of download releases the core, then the second pulse
		#1 ioctl_download = 1'b0;
		wait_reset_level(1'b0, 4, n);
		if (core_reset || n > 2) begin
			$display("core_reset did not fall within 2 cycles after the download ended");
			errors++;
		end
		wait_reset_level(1'b1, 300, n);
		check_val("core_reset pulse delay", 32'(arcade_pkg::RESET_HOLD), 32'(n + 1));
		@(posedge clk_sys);
		#1 check_val("core_reset", 32'd0, 32'(core_reset));
		#1 status_reset = 1'b1;
		@(posedge clk_sys);
		#1 check_val("core_reset", 32'd1, 32'(core_reset));
		#1 status_reset = 1'b0;
		wait_reset_level(1'b0, 4, n);
		check_val("core_reset", 32'd0, 32'(core_reset));

		// each key and its joystick bit light one ctrl bit
		for (int i = 0; i < 11; i++) begin
			exp_ctrl = 12'd1 << (11 - i);
			key_event(key_tab[i], 1'b1);
			check_val("ctrl", 32'(exp_ctrl), 32'(ctrl));
			key_event(key_tab[i], 1'b0);
			check_val("ctrl", 32'd0, 32'(ctrl));
			apply_inputs(16'd1 << joy_tab[i], 1'b0);
			check_val("ctrl", 32'(exp_ctrl), 32'(ctrl));
			apply_inputs(16'd0, 1'b0);
		end
		for (int i = 0; i < 4; i++) begin
			dirs = ref_rotate(4'd1 << (3 - i));
			apply_inputs(16'd1 << joy_tab[i], 1'b1);
			check_val("ctrl directions", 32'(dirs), 32'(ctrl[11:8]));
		end
		apply_inputs(16'd0, 1'b0);

		// gearbox toggles on each shift press, coin clears it
		for (int i = 0; i < 2; i++) begin
			key_event(arcade_pkg::KEY_SHIFT, 1'b1);
			exp_shift = ~exp_shift;
			check_val("ctrl.shift_state", 32'(exp_shift), 32'(ctrl.shift_state));
			key_event(arcade_pkg::KEY_SHIFT, 1'b0);
			check_val("ctrl.shift_state", 32'(exp_shift), 32'(ctrl.shift_state));
		end
		apply_inputs(16'd1 << arcade_pkg::JOY_FIRE_C, 1'b0);
		exp_shift = ~exp_shift;
		check_val("ctrl.shift_state", 32'(exp_shift), 32'(ctrl.shift_state));
		apply_inputs(16'd0, 1'b0);
		key_event(arcade_pkg::KEY_COIN, 1'b1);
		check_val("ctrl", 32'(12'b0000_0000_0100), 32'(ctrl));
		key_event(arcade_pkg::KEY_COIN, 1'b0);

		// steering to both ends and back to center, gas up, hold and down
		analog_phase(16'd1 << arcade_pkg::JOY_RIGHT, 40);
		analog_phase(16'd0, 40);
		analog_phase(16'd1 << arcade_pkg::JOY_LEFT, 40);
		analog_phase((16'd1 << arcade_pkg::JOY_LEFT) | (16'd1 << arcade_pkg::JOY_RIGHT), 40);
		analog_phase(16'd1 << arcade_pkg::JOY_UP, 40);
		analog_phase(16'd0, 4);
		analog_phase(16'd1 << arcade_pkg::JOY_DOWN, 40);

		$display("tests finished with %0d checks and %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		repeat (WDOG_CYCLES) @(posedge clk_sys);
		$display("watchdog timeout after %0d cycles, the tests did not finish", WDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
arcade_pkg.sv
rom_loader.sv
reset_gen.sv
control_mapper.sv
analog_control.sv
spyhunt_front.sv
tb_spyhunt_front.sv

// File: run_sim.sh
#!/bin/sh
# build and run the front end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f all.f \
	--top-module tb_spyhunt_front \
	-o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation result: pass"
	exit 0
else
	echo "simulation result: fail"
	exit 1
fi
